/* filelist.f */
+incdir+source
source/sample_pkg.sv
source/frame_ctrl_pkg.sv
source/sample_fifo.sv
source/window_buffer.sv
source/window_taper.sv
source/frame_window_top.sv
testbench/tb_frame_window.sv

/* source/frame_ctrl_pkg.sv */
`include "frame_defs.svh"

package frame_ctrl_pkg;

    // frame store fill sequence.
    typedef enum logic [2:0] {
        IDLE,
        START,
        MOVE,
        REQUEST_DATA,
        FILL
    } fill_state_t;

    // taper read sequence.
    typedef enum logic [1:0] {
        WAIT_FRAME,
        STREAM,
        ADVANCE
    } taper_state_t;

endpackage

/* source/frame_defs.svh */
`ifndef FRAME_DEFS_SVH
`define FRAME_DEFS_SVH

// width of one audio sample.
`define SAMPLE_W 16

// samples per frame.
`define FRAME_SIZE 306

// hop between frame starts.
`define MOVE_SIZE 123

// input fifo entries, power of two.
`define FIFO_DEPTH 512

// tapered output width.
`define PRODUCT_W 24

`endif

/* source/frame_window_top.sv */
`timescale 1ns/1ps

module frame_window_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_valid_i,
    input  sample_pkg::sample_t    sample_i,
    output logic                   fifo_full_o,
    output logic                   out_valid_o,
    output sample_pkg::product_t   out_sample_o,
    output sample_pkg::frame_idx_t out_index_o,
    output logic                   out_last_o
);
    import sample_pkg::*;

    logic    fifo_rd_en;
    logic    fifo_empty;
    sample_t fifo_data;
    sample_t buf_data;
    logic    buf_valid;
    logic    buf_rd_en;
    logic    frame_ready;
    logic    move_req;

    sample_fifo i_sample_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (sample_valid_i),
        .wr_data_i (sample_i),
        .rd_en_i   (fifo_rd_en),
        .rd_data_o (fifo_data),
        .empty_o   (fifo_empty),
        .full_o    (fifo_full_o)
    );

    window_buffer i_window_buffer (
        .clk                (clk),
        .rst_n              (rst_n),
        .start_move_i       (move_req),
        .fifo_data_i        (fifo_data),
        .fifo_empty_i       (fifo_empty),
        .rd_en_i            (buf_rd_en),
        .fifo_rd_en_o       (fifo_rd_en),
        .read_data_o        (buf_data),
        .valid_to_read_o    (buf_valid),
        .start_next_state_o (frame_ready)
    );

    window_taper i_window_taper (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_ready_i (frame_ready),
        .buf_data_i    (buf_data),
        .buf_valid_i   (buf_valid),
        .buf_rd_en_o   (buf_rd_en),
        .move_req_o    (move_req),
        .out_valid_o   (out_valid_o),
        .out_sample_o  (out_sample_o),
        .out_index_o   (out_index_o),
        .out_last_o    (out_last_o)
    );

endmodule

/* source/sample_fifo.sv */
`timescale 1ns/1ps
`include "frame_defs.svh"

module sample_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en_i,
    input  sample_pkg::sample_t wr_data_i,
    input  logic                rd_en_i,
    output sample_pkg::sample_t rd_data_o,
    output logic                empty_o,
    output logic                full_o
);
    import sample_pkg::*;

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);
    localparam logic [ADDR_W:0] DEPTH_CNT = (ADDR_W + 1)'(`FIFO_DEPTH);

    sample_t           mem [`FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              wr_ok;
    logic              rd_ok;

    assign empty_o = (count == '0);
    assign full_o  = (count == DEPTH_CNT);

    // writes while full are dropped.
    assign wr_ok = wr_en_i && !full_o;
    assign rd_ok = rd_en_i && !empty_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the request.
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

endmodule

/* source/sample_pkg.sv */
`include "frame_defs.svh"

package sample_pkg;

    // signed audio sample.
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // sample times taper weight.
    typedef logic signed [`PRODUCT_W-1:0] product_t;

    // position within a frame or the frame store.
    typedef logic [$clog2(`FRAME_SIZE)-1:0] frame_idx_t;

    // triangular weight, peaks at 152.
    typedef logic [7:0] weight_t;

endpackage

/* source/window_buffer.sv */
`timescale 1ns/1ps
`include "frame_defs.svh"

module window_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_move_i,
    input  sample_pkg::sample_t fifo_data_i,
    input  logic                fifo_empty_i,
    input  logic                rd_en_i,
    output logic                fifo_rd_en_o,
    output sample_pkg::sample_t read_data_o,
    output logic                valid_to_read_o,
    output logic                start_next_state_o
);
    import sample_pkg::*;
    import frame_ctrl_pkg::*;

    localparam int PTR_W = $bits(frame_idx_t);
    localparam int CNT_W = $clog2(`FRAME_SIZE + 1);

    localparam logic [PTR_W:0]   FRAME_WIDE = (PTR_W + 1)'(`FRAME_SIZE);
    localparam frame_idx_t       LAST_POS   = frame_idx_t'(`FRAME_SIZE - 1);
    localparam frame_idx_t       MOVE_POS   = frame_idx_t'(`MOVE_SIZE);
    localparam logic [CNT_W-1:0] FRAME_CNT  = CNT_W'(`FRAME_SIZE);
    localparam logic [CNT_W-1:0] MOVE_CNT   = CNT_W'(`MOVE_SIZE);
    localparam logic [CNT_W-1:0] KEEP_CNT   = CNT_W'(`FRAME_SIZE - `MOVE_SIZE);

    sample_t          buffer [`FRAME_SIZE];
    fill_state_t      state;
    fill_state_t      next_state;
    frame_idx_t       write_ptr;
    frame_idx_t       base_ptr;
    frame_idx_t       read_ptr;
    frame_idx_t       read_addr;
    logic [CNT_W-1:0] req_left;
    logic [CNT_W-1:0] write_left;
    logic [CNT_W-1:0] unread;
    logic             wr_pending;
    logic             fill_done;
    logic             rd_ok;

    // position sum modulo frame size.
    function automatic frame_idx_t wrap_add(frame_idx_t a, frame_idx_t b);
        logic [PTR_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= FRAME_WIDE) begin
            sum = sum - FRAME_WIDE;
        end
        return sum[PTR_W-1:0];
    endfunction

    // only ask while samples are still owed and the fifo has one.
    assign fifo_rd_en_o = ((state == REQUEST_DATA) || (state == FILL)) &&
                          (req_left != '0) && !fifo_empty_i;

    // last owed sample lands this cycle.
    assign fill_done = wr_pending && (write_left == CNT_W'(1));

    // unread count rather than pointer compare, a full window is not empty.
    assign valid_to_read_o = (unread != '0);
    assign rd_ok           = rd_en_i && valid_to_read_o;

    assign read_addr   = wrap_add(base_ptr, read_ptr);
    assign read_data_o = buffer[read_addr];

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (start_move_i) begin
                    next_state = MOVE;
                end
            end
            START, MOVE: begin
                next_state = REQUEST_DATA;
            end
            REQUEST_DATA: begin
                if (fill_done) begin
                    next_state = IDLE;
                end else if (!fifo_empty_i) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                if (fill_done) begin
                    next_state = IDLE;
                end else if (fifo_empty_i && (req_left != '0)) begin
                    next_state = REQUEST_DATA;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state              <= START;
            start_next_state_o <= 1'b0;
            wr_pending         <= 1'b0;
            write_ptr          <= '0;
            base_ptr           <= '0;
            read_ptr           <= '0;
            req_left           <= '0;
            write_left         <= '0;
            unread             <= '0;
        end else begin
            state              <= next_state;
            start_next_state_o <= (state == START) || (state == MOVE);
            wr_pending         <= fifo_rd_en_o;

            if (fifo_rd_en_o) begin
                req_left <= req_left - 1'b1;
            end
            if (wr_pending) begin
                write_ptr  <= (write_ptr == LAST_POS) ? '0 : write_ptr + 1'b1;
                write_left <= write_left - 1'b1;
            end
            if (rd_ok) begin
                read_ptr <= (read_ptr == LAST_POS) ? '0 : read_ptr + 1'b1;
            end
            case ({wr_pending, rd_ok})
                2'b10:   unread <= unread + 1'b1;
                2'b01:   unread <= unread - 1'b1;
                default: unread <= unread;
            endcase

            // a new frame restarts the counters.
            if (state == START) begin
                req_left   <= FRAME_CNT;
                write_left <= FRAME_CNT;
                unread     <= '0;
                base_ptr   <= '0;
                read_ptr   <= '0;
            end else if (state == MOVE) begin
                // older part of the frame is already stored.
                req_left   <= MOVE_CNT;
                write_left <= MOVE_CNT;
                unread     <= KEEP_CNT;
                base_ptr   <= wrap_add(base_ptr, MOVE_POS);
                read_ptr   <= '0;
            end
        end
    end

    // sample fetched last cycle goes into the store.
    always_ff @(posedge clk) begin
        if (wr_pending) begin
            buffer[write_ptr] <= fifo_data_i;
        end
    end

endmodule

/* source/window_taper.sv */
`timescale 1ns/1ps
`include "frame_defs.svh"

module window_taper (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_ready_i,
    input  sample_pkg::sample_t    buf_data_i,
    input  logic                   buf_valid_i,
    output logic                   buf_rd_en_o,
    output logic                   move_req_o,
    output logic                   out_valid_o,
    output sample_pkg::product_t   out_sample_o,
    output sample_pkg::frame_idx_t out_index_o,
    output logic                   out_last_o
);
    import sample_pkg::*;
    import frame_ctrl_pkg::*;

    localparam frame_idx_t LAST_IDX = frame_idx_t'(`FRAME_SIZE - 1);
    localparam int         FULL_W   = $bits(sample_t) + $bits(weight_t) + 1;

    taper_state_t             state;
    taper_state_t             next_state;
    frame_idx_t               idx;
    frame_idx_t               mirror_idx;
    weight_t                  weight;
    logic                     accept;
    logic                     last_read;
    logic signed [FULL_W-1:0] full_product;

    // read every cycle of a frame, the buffer paces it with valid.
    assign buf_rd_en_o = (state == STREAM);
    assign accept      = buf_rd_en_o && buf_valid_i;
    assign last_read   = accept && (idx == LAST_IDX);

    // distance to the nearer frame edge.
    assign mirror_idx = LAST_IDX - idx;
    assign weight     = (idx < mirror_idx) ? weight_t'(idx) : weight_t'(mirror_idx);

    // weight is unsigned, zero extend before the signed multiply.
    assign full_product = buf_data_i * $signed({1'b0, weight});

    always_comb begin
        next_state = state;
        unique case (state)
            WAIT_FRAME: begin
                if (frame_ready_i) begin
                    next_state = STREAM;
                end
            end
            STREAM: begin
                if (last_read) begin
                    next_state = ADVANCE;
                end
            end
            ADVANCE: begin
                next_state = WAIT_FRAME;
            end
            default: next_state = WAIT_FRAME;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= WAIT_FRAME;
            idx         <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
            move_req_o  <= 1'b0;
        end else begin
            state       <= next_state;
            out_valid_o <= accept;
            out_last_o  <= last_read;

            // one cycle after the last output.
            move_req_o  <= (state == ADVANCE);

            if (accept) begin
                idx <= last_read ? '0 : idx + 1'b1;
            end
        end
    end

    // max magnitude is 32768 * 152, fits the product width.
    always_ff @(posedge clk) begin
        if (accept) begin
            out_sample_o <= product_t'(full_product);
            out_index_o  <= idx;
        end
    end

endmodule

/* testbench/tb_frame_window.sv */
`timescale 1ns/1ps
`include "frame_defs.svh"

module tb_frame_window;
    import sample_pkg::*;

    localparam int GAP_FACTOR  = 4;
    localparam int MARGIN      = 3104;
    // four frames of input at the widest gap, plus margin, 8000 cycles.
    localparam int CYCLE_LIMIT = 4 * `FRAME_SIZE * GAP_FACTOR + MARGIN;
    localparam int LAST_N      = `FRAME_SIZE - 1;

    logic       clk;
    logic       rst_n;
    logic       sample_valid_i;
    sample_t    sample_i;
    logic       fifo_full_o;
    logic       out_valid_o;
    product_t   out_sample_o;
    frame_idx_t out_index_o;
    logic       out_last_o;

    sample_t     accepted[$];
    string       test_name;
    logic [31:0] rng;
    int          sent_count;
    int          exp_k;
    int          exp_n;
    int          cycle_count;
    int          mismatch_count;
    int          other_count;

    frame_window_top i_frame_window_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .fifo_full_o    (fifo_full_o),
        .out_valid_o    (out_valid_o),
        .out_sample_o   (out_sample_o),
        .out_index_o    (out_index_o),
        .out_last_o     (out_last_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // accepted sample k*MOVE_SIZE+n times the triangular weight.
    function automatic product_t ref_tapered(int k, int n);
        int s;
        int w;
        s = int'(accepted[k * `MOVE_SIZE + n]);
        w = (n < LAST_N - n) ? n : LAST_N - n;
        return product_t'(s * w);
    endfunction

    task automatic check_sample(string name, product_t expected, product_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch in %s: sample expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_index(string name, frame_idx_t expected, frame_idx_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch in %s: index expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_last(string name, logic expected, logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch in %s: flag expected %b, actual %b", name, expected, actual);
        end
    endtask

    // one sample per falling edge, optional idle cycles before each.
    task automatic send_samples(int count, bit with_gaps);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = 0;
            if (with_gaps) begin
                rng = xorshift32(rng);
                gap = int'(rng[1:0]);
            end
            repeat (gap) begin
                @(negedge clk);
                sample_valid_i = 1'b0;
            end
            @(negedge clk);
            rng = xorshift32(rng);
            sample_valid_i = 1'b1;
            sample_i       = sample_t'(rng[15:0]);
            sent_count++;
            if (!fifo_full_o) begin
                accepted.push_back(sample_i);
            end
        end
        @(negedge clk);
        sample_valid_i = 1'b0;
    endtask

    task automatic wait_frames(int target);
        while (exp_k < target) begin
            @(posedge clk);
        end
    endtask

    // compare every output strobe against the reference.
    always @(negedge clk) begin
        if (rst_n && out_valid_o) begin
            if (exp_k * `MOVE_SIZE + exp_n >= accepted.size()) begin
                other_count++;
                $display("Error in %s: output for frame %0d index %0d has no accepted input",
                         test_name, exp_k, exp_n);
            end else begin
                check_sample(test_name, ref_tapered(exp_k, exp_n), out_sample_o);
            end
            check_index(test_name, frame_idx_t'(exp_n), out_index_o);
            check_last(test_name, (exp_n == LAST_N), out_last_o);
            if (exp_n == LAST_N) begin
                exp_n = 0;
                exp_k++;
            end else begin
                exp_n++;
            end
        end else if (rst_n && out_last_o) begin
            other_count++;
            $display("Error in %s: out_last_o is high without out_valid_o", test_name);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout in %s: run did not finish within %0d cycles",
                     test_name, CYCLE_LIMIT);
            $display("mismatches: %0d, other errors: %0d", mismatch_count, other_count + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        rng            = 32'd82026;
        sent_count     = 0;
        exp_k          = 0;
        exp_n          = 0;
        cycle_count    = 0;
        mismatch_count = 0;
        other_count    = 0;
        test_name      = "reset";

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // outputs quiet with no input.
        test_name = "idle";
        repeat (40) begin
            @(negedge clk);
            check_last("idle out_valid_o", 1'b0, out_valid_o);
            check_last("idle out_last_o", 1'b0, out_last_o);
            check_last("idle fifo_full_o", 1'b0, fifo_full_o);
        end

        test_name = "first_frame";
        send_samples(`FRAME_SIZE, 1'b0);
        wait_frames(1);

        test_name = "overlap";
        send_samples(3 * `MOVE_SIZE, 1'b0);
        wait_frames(4);

        // fifo is drained here, so gaps stall the fill.
        test_name = "random_gaps";
        send_samples(4 * `MOVE_SIZE, 1'b1);
        wait_frames(8);
        repeat (20) @(negedge clk);

        if (accepted.size() != sent_count) begin
            other_count++;
            $display("Error: %0d of %0d input samples were dropped by a full FIFO",
                     sent_count - accepted.size(), sent_count);
        end

        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
